/* ex_mem_slice.f */
logic/pipe_pkg.sv
logic/execute_unit.sv
logic/pipe_reg_ex_mem.sv
logic/mem_stage.sv
logic/ex_mem_top.sv
tests/ex_mem_checker.sv
tests/tb_ex_mem.sv

/* logic/ex_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_mem_top #(
   parameter int DMEM_WORDS = 256
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall,
   input  logic              flush_ex,
   input  pipe_pkg::id_ex_t  id_ex,
   output pipe_pkg::mem_wb_t mem_wb
);

   pipe_pkg::ex_mem_t ex_bundle;                     // Combinational EX result
   pipe_pkg::ex_mem_t mem_bundle;                    // Registered EX/MEM state

   execute_unit exec0 (
      .id_ex     (id_ex),
      .ex_bundle (ex_bundle)
   );

   pipe_reg_ex_mem exmem0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .stall      (stall),
      .flush_ex   (flush_ex),
      .ex_bundle  (ex_bundle),
      .mem_bundle (mem_bundle)
   );

   mem_stage #(
      .DMEM_WORDS (DMEM_WORDS)
   ) mem0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .stall      (stall),
      .mem_bundle (mem_bundle),
      .mem_wb     (mem_wb)
   );

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
   input  pipe_pkg::id_ex_t  id_ex,
   output pipe_pkg::ex_mem_t ex_bundle
);

   logic [pipe_pkg::XLEN-1:0] op_a;
   logic [pipe_pkg::XLEN-1:0] op_b;
   logic [pipe_pkg::XLEN-1:0] result;
   logic [4:0]                shamt;
   logic                      add_ofl;
   logic                      sub_ofl;

   assign op_a  = id_ex.reg_data_1;
   assign op_b  = id_ex.use_imm ? id_ex.imm : id_ex.reg_data_2;
   assign shamt = op_b[4:0];

   always_comb begin
      case (id_ex.alu_op)
         pipe_pkg::ADD: begin
            result = op_a + op_b;
         end
         pipe_pkg::SUB: begin
            result = op_a - op_b;
         end
         pipe_pkg::AND: begin
            result = op_a & op_b;
         end
         pipe_pkg::OR: begin
            result = op_a | op_b;
         end
         pipe_pkg::XOR: begin
            result = op_a ^ op_b;
         end
         pipe_pkg::SLT: begin
            result = {{(pipe_pkg::XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
         end
         pipe_pkg::SLL: begin
            result = op_a << shamt;
         end
         pipe_pkg::SRL: begin
            result = op_a >> shamt;                  // Logical shift with zero fill
         end
         pipe_pkg::PASS_B: begin
            result = op_b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

   // Signed overflow detection for ADD and SUB
   assign add_ofl = (op_a[pipe_pkg::XLEN-1] == op_b[pipe_pkg::XLEN-1]) &&
                    (result[pipe_pkg::XLEN-1] != op_a[pipe_pkg::XLEN-1]);
   assign sub_ofl = (op_a[pipe_pkg::XLEN-1] != op_b[pipe_pkg::XLEN-1]) &&
                    (result[pipe_pkg::XLEN-1] != op_a[pipe_pkg::XLEN-1]);

   always_comb begin
      ex_bundle.alu_out     = result;
      ex_bundle.z           = (result == '0);
      ex_bundle.n           = result[pipe_pkg::XLEN-1];
      if (id_ex.alu_op == pipe_pkg::ADD) begin
         ex_bundle.ofl = add_ofl;
      end else if (id_ex.alu_op == pipe_pkg::SUB) begin
         ex_bundle.ofl = sub_ofl;
      end else begin
         ex_bundle.ofl = 1'b0;
      end
      ex_bundle.reg_data_1  = id_ex.reg_data_1;
      ex_bundle.reg_data_2  = id_ex.reg_data_2;   // Store data
      ex_bundle.ctrl        = id_ex.ctrl;
      ex_bundle.instruction = id_ex.instruction;
      ex_bundle.pc_4        = id_ex.pc_4;
   end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
   parameter int DMEM_WORDS = 256
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall,
   input  pipe_pkg::ex_mem_t mem_bundle,
   output pipe_pkg::mem_wb_t mem_wb
);

   localparam int AW = $clog2(DMEM_WORDS);

   logic [pipe_pkg::XLEN-1:0] dmem [DMEM_WORDS];
   logic [AW-1:0]             word_addr;
   logic [pipe_pkg::XLEN-1:0] rd_word;
   logic [pipe_pkg::XLEN-1:0] lane_mask;
   logic [pipe_pkg::XLEN-1:0] load_data;
   logic [pipe_pkg::XLEN-1:0] wb_data;
   pipe_pkg::mem_wb_t         wb_next;

   assign word_addr = mem_bundle.alu_out[AW+1:2];   // Wraps modulo depth

   // Load path
   assign rd_word = dmem[word_addr];

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         lane_mask[8*i +: 8] = {8{mem_bundle.ctrl.mem_enable[i]}};
      end
   end

   assign load_data = rd_word & lane_mask;

   // Store commits only on edges without stall
   always_ff @(posedge clk) begin
      if (!stall) begin
         for (int i = 0; i < 4; i++) begin
            if (mem_bundle.ctrl.mem_write[i]) begin
               dmem[word_addr][8*i +: 8] <= mem_bundle.reg_data_2[8*i +: 8];
            end
         end
      end
   end

   always_comb begin
      case (mem_bundle.ctrl.wb_sel)
         pipe_pkg::WB_MEM: wb_data = load_data;
         pipe_pkg::WB_PC4: wb_data = mem_bundle.pc_4;
         default:          wb_data = mem_bundle.alu_out;
      endcase
   end

   always_comb begin
      wb_next.write_data    = wb_data;
      wb_next.write_reg_sel = mem_bundle.ctrl.write_reg_sel;
      wb_next.write_reg_en  = mem_bundle.ctrl.write_reg_en;
      wb_next.halt          = mem_bundle.ctrl.halt;
      wb_next.instruction   = mem_bundle.instruction;
   end

   // MEM/WB register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_wb             <= '0;
         mem_wb.instruction <= pipe_pkg::NOP_INSTR;
      end else if (!stall) begin
         mem_wb <= wb_next;
      end
   end

   a_no_rd_wr: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(mem_bundle.ctrl.mem_read && (mem_bundle.ctrl.mem_write != '0))
   ) else $error("Load and store issued together");

   a_wr_in_en: assert property (
      @(posedge clk) disable iff (!rst_n)
      ((mem_bundle.ctrl.mem_write & ~mem_bundle.ctrl.mem_enable) == '0)
   ) else $error("Write lane outside enabled lanes");

endmodule

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

   parameter int XLEN = 32;

   typedef enum logic [3:0] {
      ADD    = 4'd0,
      SUB    = 4'd1,
      AND    = 4'd2,
      OR     = 4'd3,
      XOR    = 4'd4,
      SLT    = 4'd5,                                 // Signed compare
      SLL    = 4'd6,
      SRL    = 4'd7,
      PASS_B = 4'd8                                  // Address and immediate moves
   } alu_op_e;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2
   } wb_sel_e;

   typedef struct packed {
      logic [3:0] mem_write;                         // Byte write enables
      logic [3:0] mem_enable;                        // Byte access enables
      logic       mem_read;
      wb_sel_e    wb_sel;
      logic [4:0] write_reg_sel;
      logic       write_reg_en;
      logic       halt;
   } ex_ctrl_t;

   typedef struct packed {
      alu_op_e         alu_op;
      logic [XLEN-1:0] reg_data_1;
      logic [XLEN-1:0] reg_data_2;
      logic [XLEN-1:0] imm;
      logic            use_imm;
      ex_ctrl_t        ctrl;
      logic [XLEN-1:0] instruction;
      logic [XLEN-1:0] pc_4;
   } id_ex_t;

   typedef struct packed {
      logic [XLEN-1:0] alu_out;
      logic            z;
      logic            n;
      logic            ofl;
      logic [XLEN-1:0] reg_data_1;
      logic [XLEN-1:0] reg_data_2;
      ex_ctrl_t        ctrl;
      logic [XLEN-1:0] instruction;
      logic [XLEN-1:0] pc_4;
   } ex_mem_t;

   typedef struct packed {
      logic [XLEN-1:0] write_data;
      logic [4:0]      write_reg_sel;
      logic            write_reg_en;
      logic            halt;
      logic [XLEN-1:0] instruction;
   } mem_wb_t;

   // Bubble inserted on flush
   localparam logic [XLEN-1:0] NOP_INSTR = {6'b000001, 26'b0};

endpackage

`default_nettype wire

/* logic/pipe_reg_ex_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_reg_ex_mem (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall,
   input  logic              flush_ex,
   input  pipe_pkg::ex_mem_t ex_bundle,
   output pipe_pkg::ex_mem_t mem_bundle
);

   pipe_pkg::ex_mem_t load_val;

   // Flush squashes side effects while data fields still flow
   always_comb begin
      load_val = ex_bundle;
      if (flush_ex) begin
         load_val.ctrl.mem_write    = '0;
         load_val.ctrl.mem_enable   = '0;
         load_val.ctrl.mem_read     = 1'b0;
         load_val.ctrl.write_reg_en = 1'b0;
         load_val.ctrl.halt         = 1'b0;
         load_val.instruction       = pipe_pkg::NOP_INSTR;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_bundle             <= '0;
         mem_bundle.instruction <= pipe_pkg::NOP_INSTR;
      end else if (!stall) begin                    // Stall wins over flush
         mem_bundle <= load_val;
      end
   end

   // A flushed op never leaves side effects in the MEM stage
   a_flush_bubble: assert property (
      @(posedge clk) disable iff (!rst_n)
      (flush_ex && !stall) |=>
         (!mem_bundle.ctrl.write_reg_en && (mem_bundle.ctrl.mem_write == '0) &&
          !mem_bundle.ctrl.halt)
   ) else $error("EX/MEM flush left side-effecting controls set");

endmodule

`default_nettype wire

/* tests/ex_mem_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_mem_checker #(
   parameter int DMEM_WORDS = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall,
   input  logic              flush_ex,
   input  pipe_pkg::id_ex_t  id_ex,
   input  pipe_pkg::mem_wb_t mem_wb,
   output int                check_count,
   output int                error_count
);

   pipe_pkg::ex_mem_t exm_q;                         // Model of EX/MEM
   pipe_pkg::mem_wb_t wb_q;                          // Model of MEM/WB
   logic [31:0]       model_mem [DMEM_WORDS];
   logic              started;

   function automatic logic [31:0] alu_ref(input pipe_pkg::alu_op_e op,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
      logic [31:0] r;
      case (op)
         pipe_pkg::ADD:    r = a + b;
         pipe_pkg::SUB:    r = a + ~b + 32'd1;
         pipe_pkg::AND:    r = a & b;
         pipe_pkg::OR:     r = a | b;
         pipe_pkg::XOR:    r = a ^ b;
         pipe_pkg::SLT:    r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
         pipe_pkg::SLL:    r = a << b[4:0];
         pipe_pkg::SRL:    r = a >> b[4:0];
         pipe_pkg::PASS_B: r = b;
         default:          r = 32'h0;
      endcase
      return r;
   endfunction

   task automatic compare_field(input string name,
                                input logic [31:0] exp,
                                input logic [31:0] act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("** Error at %0t ns: mem_wb.%s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   initial begin
      check_count = 0;
      error_count = 0;
      started     = 1'b0;
   end

   always @(posedge clk) begin : model_step
      int                waddr;
      logic [31:0]       rdata;
      logic [31:0]       opb;
      pipe_pkg::ex_mem_t nxt;
      started = 1'b1;
      if (!rst_n) begin
         exm_q             = '0;
         exm_q.instruction = pipe_pkg::NOP_INSTR;
         wb_q              = '0;
         wb_q.instruction  = pipe_pkg::NOP_INSTR;
      end else if (!stall) begin
         waddr = (exm_q.alu_out >> 2) % DMEM_WORDS;
         rdata = 32'h0;
         for (int i = 0; i < 4; i++) begin
            if (exm_q.ctrl.mem_enable[i]) rdata[8*i +: 8] = model_mem[waddr][8*i +: 8];
         end
         if (exm_q.ctrl.wb_sel == pipe_pkg::WB_MEM) wb_q.write_data = rdata;
         else if (exm_q.ctrl.wb_sel == pipe_pkg::WB_PC4) wb_q.write_data = exm_q.pc_4;
         else wb_q.write_data = exm_q.alu_out;
         wb_q.write_reg_sel = exm_q.ctrl.write_reg_sel;
         wb_q.write_reg_en  = exm_q.ctrl.write_reg_en;
         wb_q.halt          = exm_q.ctrl.halt;
         wb_q.instruction   = exm_q.instruction;
         for (int i = 0; i < 4; i++) begin       // Store after the read as in hardware
            if (exm_q.ctrl.mem_write[i]) model_mem[waddr][8*i +: 8] = exm_q.reg_data_2[8*i +: 8];
         end
         opb             = id_ex.use_imm ? id_ex.imm : id_ex.reg_data_2;
         nxt             = '0;
         nxt.alu_out     = alu_ref(id_ex.alu_op, id_ex.reg_data_1, opb);
         nxt.reg_data_1  = id_ex.reg_data_1;
         nxt.reg_data_2  = id_ex.reg_data_2;
         nxt.ctrl        = id_ex.ctrl;
         nxt.instruction = id_ex.instruction;
         nxt.pc_4        = id_ex.pc_4;
         if (flush_ex) begin                     // Bubble keeps data and drops side effects
            nxt.ctrl.mem_write    = 4'h0;
            nxt.ctrl.mem_enable   = 4'h0;
            nxt.ctrl.mem_read     = 1'b0;
            nxt.ctrl.write_reg_en = 1'b0;
            nxt.ctrl.halt         = 1'b0;
            nxt.instruction       = pipe_pkg::NOP_INSTR;
         end
         exm_q = nxt;
      end
   end

   always @(negedge clk) begin
      if (started) begin
         compare_field("write_data", wb_q.write_data, mem_wb.write_data);
         compare_field("write_reg_sel", {27'b0, wb_q.write_reg_sel},
                       {27'b0, mem_wb.write_reg_sel});
         compare_field("write_reg_en", {31'b0, wb_q.write_reg_en}, {31'b0, mem_wb.write_reg_en});
         compare_field("halt", {31'b0, wb_q.halt}, {31'b0, mem_wb.halt});
         compare_field("instruction", wb_q.instruction, mem_wb.instruction);
      end
   end

endmodule

`default_nettype wire

/* tests/tb_ex_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ex_mem;

   localparam int NUM_OPS    = 400;
   localparam int MEM_WORDS  = 16;
   localparam int MAX_CYCLES = 2 * NUM_OPS + 100;

   logic              clk;
   logic              rst_n;
   logic              stall;
   logic              flush_ex;
   pipe_pkg::id_ex_t  id_ex;
   pipe_pkg::mem_wb_t mem_wb;
   int                check_count;
   int                error_count;
   int                cycle_count;
   int                ops_done;
   integer            seed;

   ex_mem_top #(.DMEM_WORDS(MEM_WORDS)) dut0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .stall    (stall),
      .flush_ex (flush_ex),
      .id_ex    (id_ex),
      .mem_wb   (mem_wb)
   );

   ex_mem_checker #(.DMEM_WORDS(MEM_WORDS)) chk0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .flush_ex    (flush_ex),
      .id_ex       (id_ex),
      .mem_wb      (mem_wb),
      .check_count (check_count),
      .error_count (error_count)
   );

   always #10 clk = ~clk;

   task automatic random_op(output pipe_pkg::id_ex_t op);
      logic [3:0] op_sel;
      logic [3:0] en;
      op                    = '0;
      op_sel                = $unsigned($random(seed)) % 9;
      op.alu_op             = pipe_pkg::alu_op_e'(op_sel);
      op.reg_data_1         = $random(seed);
      op.reg_data_2         = $random(seed);
      op.imm                = $random(seed);
      op.use_imm            = $random(seed);
      op.instruction        = $random(seed);
      op.pc_4               = $random(seed);
      op.ctrl.write_reg_sel = $random(seed);
      op.ctrl.write_reg_en  = $random(seed);
      op.ctrl.halt          = ($unsigned($random(seed)) % 16) == 0;
      op.ctrl.wb_sel        = pipe_pkg::wb_sel_e'($unsigned($random(seed)) % 3);
      en                    = $random(seed);
      if (en == 4'h0) en = 4'h1;
      case ($unsigned($random(seed)) % 4)
         0: begin                                    // Load
            op.ctrl.mem_read   = 1'b1;
            op.ctrl.mem_enable = en;
            op.ctrl.wb_sel     = pipe_pkg::WB_MEM;
         end
         1: begin                                    // Store with write lanes inside the enables
            op.ctrl.mem_enable = en;
            op.ctrl.mem_write  = en & $random(seed);
         end
         default: begin
         end
      endcase
   endtask

   initial begin
      clk      = 1'b0;
      rst_n    = 1'b0;
      stall    = 1'b0;
      flush_ex = 1'b0;
      id_ex    = '0;
      seed     = 99;
      ops_done = 0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      for (int w = 0; w < MEM_WORDS; w++) begin  // Fill every word so loads are defined
         id_ex                 = '0;
         id_ex.alu_op          = pipe_pkg::PASS_B;
         id_ex.use_imm         = 1'b1;
         id_ex.imm             = w * 4;
         id_ex.reg_data_2      = $random(seed);
         id_ex.ctrl.mem_write  = 4'hF;
         id_ex.ctrl.mem_enable = 4'hF;
         @(posedge clk);
         #2;
      end
      while (ops_done < NUM_OPS) begin
         if (!stall) random_op(id_ex);           // A stalled op is presented again
         stall    = ($unsigned($random(seed)) % 4) == 0;
         flush_ex = ($unsigned($random(seed)) % 10) == 0;
         if (!stall) ops_done++;
         @(posedge clk);
         #2;
      end
      stall    = 1'b0;
      flush_ex = 1'b0;
      id_ex    = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      #1;
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire
